// File: if_pkg.sv
package if_pkg;

  ////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////

  // byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // one fetched instruction word
  typedef logic [31:0] instr_t;

  // interrupt number used for vectored mtvec
  typedef logic [4:0] irq_id_t;

  ////////////////////////////////////////////////////////////
  // selectors driven by the controller
  ////////////////////////////////////////////////////////////

  // source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which vector to take when pc_sel_e is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // low byte of the boot pc, upper bits come from boot_addr_i
  localparam logic [7:0] BootOffset = 8'h80;
  // mtvec base is 256-byte aligned in vectored mode
  localparam int unsigned VecAlignBits = 8;
  // word fetch only, so every sequential step is one word
  localparam int unsigned InstrBytes = 4;

endpackage

// File: if_pc_select.sv
`timescale 1ns/1ns

module if_pc_select import if_pkg::*; #(
  parameter addr_t DmHaltAddr      = 32'h1A110800,
  parameter addr_t DmExceptionAddr = 32'h1A110808
) (
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_id_t     irq_id_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output addr_t       fetch_addr_o
);

  addr_t mtvec_base;
  addr_t irq_offset;
  addr_t exc_pc;
  addr_t sel_addr;

  // mtvec base with the mode bits and the low byte stripped
  assign mtvec_base = {csr_mtvec_i[31:VecAlignBits], {VecAlignBits{1'b0}}};
  // one jump instruction per vector table entry
  assign irq_offset = addr_t'(irq_id_i) * addr_t'(InstrBytes);

  // exception / interrupt / debug entry point
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // mtvec bit 0 set selects vectored mode
      EXC_PC_IRQ:     exc_pc = csr_mtvec_i[0] ? (mtvec_base + irq_offset) : mtvec_base;
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = mtvec_base;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: sel_addr = {boot_addr_i[31:8], BootOffset};
      PC_JUMP: sel_addr = branch_target_i;
      PC_EXC:  sel_addr = exc_pc;
      // return from trap handler
      PC_ERET: sel_addr = csr_mepc_i;
      // return from debug mode
      PC_DRET: sel_addr = csr_depc_i;
      default: sel_addr = {boot_addr_i[31:8], BootOffset};
    endcase
  end

  // fetches are whole words, drop the byte offset
  assign fetch_addr_o = {sel_addr[31:2], 2'b00};

endmodule

// File: if_fetch_fsm.sv
`timescale 1ns/1ns

module if_fetch_fsm import if_pkg::*; #(
  parameter int unsigned FifoDepth      = 3,
  parameter int unsigned MaxOutstanding = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       pc_set_i,
  input  addr_t      fetch_addr_i,
  input  logic       instr_gnt_i,
  input  logic [1:0] outstanding_i,
  input  logic [2:0] fifo_count_i,
  output logic       instr_req_o,
  output addr_t      instr_addr_o,
  output logic       grant_o,
  output logic       grant_stale_o,
  output logic       busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_GNT_STALE
  } fetch_state_e;

  fetch_state_e state_q, state_d;
  addr_t        fetch_addr_q;
  addr_t        stale_addr_q;
  logic         started_q;
  logic [3:0]   fill;
  logic         can_req;

  // slots already claimed in the fifo, counting responses still on the bus
  assign fill = {2'b00, outstanding_i} + {1'b0, fifo_count_i};

  // new request only with a known address and room for its response
  // no issue in a redirect cycle, the address is about to change
  assign can_req = req_i & started_q & ~pc_set_i &
                   (outstanding_i < 2'(MaxOutstanding)) &
                   (fill < 4'(FifoDepth));

  // once raised the request stays up until granted
  assign instr_req_o  = (state_q != IDLE) | can_req;
  assign instr_addr_o = (state_q == WAIT_GNT_STALE) ? stale_addr_q : fetch_addr_q;

  assign grant_o       = instr_req_o & instr_gnt_i;
  assign grant_stale_o = (state_q == WAIT_GNT_STALE) & instr_gnt_i;
  assign busy_o        = (state_q != IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (can_req && !instr_gnt_i) begin
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = IDLE;
        end else if (pc_set_i) begin
          // redirect while waiting, keep the old request but mark it
          state_d = WAIT_GNT_STALE;
        end
      end
      WAIT_GNT_STALE: begin
        if (instr_gnt_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      started_q    <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      state_q <= state_d;
      // nothing is fetched before the first redirect (boot)
      if (pc_set_i) begin
        started_q <= 1'b1;
      end
      if (pc_set_i) begin
        fetch_addr_q <= fetch_addr_i;
      end else if (grant_o && state_q != WAIT_GNT_STALE) begin
        fetch_addr_q <= fetch_addr_q + addr_t'(InstrBytes);
      end
    end
  end

  // address of the pending request frozen at the redirect
  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_GNT && state_d == WAIT_GNT_STALE) begin
      stale_addr_q <= fetch_addr_q;
    end
  end

endmodule

// File: if_rsp_counter.sv
`timescale 1ns/1ns

module if_rsp_counter #(
  parameter int unsigned MaxOutstanding = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       grant_i,
  input  logic       grant_stale_i,
  input  logic       pc_set_i,
  input  logic       instr_rvalid_i,
  output logic [1:0] outstanding_o,
  output logic       rsp_discard_o,
  output logic       busy_o
);

  logic [1:0] outstanding_q, outstanding_d;
  logic [1:0] discard_q, discard_d;
  logic       inc;

  // the fsm never issues past the limit, count saturates there
  assign inc = grant_i & (outstanding_q != 2'(MaxOutstanding));

  always_comb begin
    outstanding_d = outstanding_q;
    if (inc && !instr_rvalid_i) begin
      outstanding_d = outstanding_q + 2'd1;
    end else if (!inc && instr_rvalid_i) begin
      outstanding_d = outstanding_q - 2'd1;
    end
  end

  // responses still to be dropped, oldest first
  always_comb begin
    discard_d = discard_q;
    if (pc_set_i) begin
      // everything still on the bus after this edge is stale
      discard_d = outstanding_d;
    end else begin
      if (rsp_discard_o) begin
        discard_d = discard_d - 2'd1;
      end
      if (grant_stale_i) begin
        discard_d = discard_d + 2'd1;
      end
    end
  end

  assign rsp_discard_o = instr_rvalid_i & (discard_q != 2'd0);
  assign outstanding_o = outstanding_q;
  assign busy_o        = (outstanding_q != 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 2'd0;
      discard_q     <= 2'd0;
    end else begin
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

endmodule

// File: if_fetch_fifo.sv
`timescale 1ns/1ns

module if_fetch_fifo import if_pkg::*; #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  addr_t      flush_addr_i,
  input  logic       push_i,
  input  instr_t     rdata_i,
  input  logic       err_i,
  input  logic       ready_i,
  output logic       valid_o,
  output instr_t     rdata_o,
  output addr_t      addr_o,
  output logic       err_o,
  output logic [2:0] count_o
);

  localparam int unsigned PtrW = $clog2(FifoDepth);

  instr_t            rdata_mem [FifoDepth];
  logic              err_mem   [FifoDepth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [2:0]        count_q;
  addr_t             addr_q;
  logic              pop;

  // pointer step with wrap for depths that are not a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign valid_o = (count_q != 3'd0);
  assign pop     = valid_o & ready_i;
  assign rdata_o = rdata_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];
  assign addr_o  = addr_q;
  assign count_o = count_q;

  // pointers and count, flush wins over push and pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 3'd0;
      addr_q   <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 3'd0;
      addr_q   <= flush_addr_i;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
        // head address follows the sequential stream
        addr_q   <= addr_q + addr_t'(InstrBytes);
      end
      if (push_i && !pop) begin
        count_q <= count_q + 3'd1;
      end else if (!push_i && pop) begin
        count_q <= count_q - 3'd1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      rdata_mem[wr_ptr_q] <= rdata_i;
      err_mem[wr_ptr_q]   <= err_i;
    end
  end

endmodule

// File: if_id_reg.sv
`timescale 1ns/1ns

module if_id_reg import if_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_valid_i,
  input  instr_t fetch_rdata_i,
  input  addr_t  fetch_addr_i,
  input  logic   fetch_err_i,
  input  logic   id_in_ready_i,
  input  logic   pc_set_i,
  input  logic   instr_valid_clear_i,
  output logic   fetch_ready_o,
  output logic   instr_valid_id_o,
  output logic   instr_new_id_o,
  output instr_t instr_rdata_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_id_o,
  output logic   pc_mismatch_alert_o
);

  logic  accept;
  logic  valid_d;
  logic  new_d;
  logic  prev_seq_q, prev_seq_d;
  addr_t pc_id_incr;

  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;

  // an entry taken in a redirect cycle is squashed
  assign new_d   = accept & ~pc_set_i;
  // valid holds until the controller clears it
  assign valid_d = new_d | (instr_valid_id_o & ~instr_valid_clear_i);

  ////////////////////////////////////////////////////////////
  // pc increment hardening
  ////////////////////////////////////////////////////////////

  // sequential unless a redirect or a bus error broke the stream
  assign prev_seq_d = (prev_seq_q | new_d) & ~pc_set_i & ~(accept & fetch_err_i);
  assign pc_id_incr = pc_id_o + addr_t'(InstrBytes);

  // if pc must be one word past the instruction in id
  assign pc_mismatch_alert_o = prev_seq_q & (fetch_addr_i != pc_id_incr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
      prev_seq_q       <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= new_d;
      prev_seq_q       <= prev_seq_d;
    end
  end

  // pipeline data, frozen while id stalls
  always_ff @(posedge clk_i) begin
    if (new_d) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      instr_fetch_err_o <= fetch_err_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

endmodule

// File: if_stage.sv
`timescale 1ns/1ns

module if_stage import if_pkg::*; #(
  parameter addr_t       DmHaltAddr      = 32'h1A110800,
  parameter addr_t       DmExceptionAddr = 32'h1A110808,
  parameter int unsigned FifoDepth       = 3,
  parameter int unsigned MaxOutstanding  = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // controller requests
  input  logic        req_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_id_t     irq_id_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  input  logic        instr_valid_clear_i,
  input  logic        id_in_ready_i,

  // instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_i,

  // to the id stage
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_id_o,
  output addr_t       pc_if_o,
  output logic        pc_mismatch_alert_o,
  output logic        if_busy_o,
  output logic        csr_mtvec_init_o
);

  addr_t      fetch_addr_n;
  logic       fetch_valid;
  logic       fetch_ready;
  instr_t     fetch_rdata;
  addr_t      fetch_addr;
  logic       fetch_err;
  logic [2:0] fifo_count;
  logic [1:0] outstanding;
  logic       grant;
  logic       grant_stale;
  logic       rsp_discard;
  logic       fifo_push;
  logic       fsm_busy;
  logic       cnt_busy;

  // csr file loads mtvec at boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);
  assign if_busy_o        = fsm_busy | cnt_busy;
  assign pc_if_o          = fetch_addr;

  // drop responses of flushed requests
  assign fifo_push = instr_rvalid_i & ~rsp_discard;

  if_pc_select #(
    .DmHaltAddr     (DmHaltAddr),
    .DmExceptionAddr(DmExceptionAddr)
  ) i_pc_select (
    .pc_mux_i       (pc_mux_i),
    .exc_pc_mux_i   (exc_pc_mux_i),
    .irq_id_i       (irq_id_i),
    .boot_addr_i    (boot_addr_i),
    .branch_target_i(branch_target_i),
    .csr_mepc_i     (csr_mepc_i),
    .csr_depc_i     (csr_depc_i),
    .csr_mtvec_i    (csr_mtvec_i),
    .fetch_addr_o   (fetch_addr_n)
  );

  if_fetch_fsm #(
    .FifoDepth     (FifoDepth),
    .MaxOutstanding(MaxOutstanding)
  ) i_fetch_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .pc_set_i     (pc_set_i),
    .fetch_addr_i (fetch_addr_n),
    .instr_gnt_i  (instr_gnt_i),
    .outstanding_i(outstanding),
    .fifo_count_i (fifo_count),
    .instr_req_o  (instr_req_o),
    .instr_addr_o (instr_addr_o),
    .grant_o      (grant),
    .grant_stale_o(grant_stale),
    .busy_o       (fsm_busy)
  );

  if_rsp_counter #(
    .MaxOutstanding(MaxOutstanding)
  ) i_rsp_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .grant_i       (grant),
    .grant_stale_i (grant_stale),
    .pc_set_i      (pc_set_i),
    .instr_rvalid_i(instr_rvalid_i),
    .outstanding_o (outstanding),
    .rsp_discard_o (rsp_discard),
    .busy_o        (cnt_busy)
  );

  if_fetch_fifo #(
    .FifoDepth(FifoDepth)
  ) i_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (pc_set_i),
    .flush_addr_i(fetch_addr_n),
    .push_i      (fifo_push),
    .rdata_i     (instr_rdata_i),
    .err_i       (instr_err_i),
    .ready_i     (fetch_ready),
    .valid_o     (fetch_valid),
    .rdata_o     (fetch_rdata),
    .addr_o      (fetch_addr),
    .err_o       (fetch_err),
    .count_o     (fifo_count)
  );

  if_id_reg i_id_reg (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid),
    .fetch_rdata_i      (fetch_rdata),
    .fetch_addr_i       (fetch_addr),
    .fetch_err_i        (fetch_err),
    .id_in_ready_i      (id_in_ready_i),
    .pc_set_i           (pc_set_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .fetch_ready_o      (fetch_ready),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .pc_id_o            (pc_id_o),
    .pc_mismatch_alert_o(pc_mismatch_alert_o)
  );

endmodule

// File: tb_instr_mem.sv
`timescale 1ns/1ns

module tb_instr_mem (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  // cycles left before the next grant
  logic [1:0]  gnt_wait_q;
  // granted requests waiting for their response, oldest first
  logic [31:0] pend_addr[$];
  int          pend_due[$];
  int          cycle_cnt;
  int          last_due;
  int          due;

  // grant may come in the same cycle as the request
  assign gnt_o = req_i & (gnt_wait_q == 2'd0);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_wait_q <= 2'd0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
      err_o      <= 1'b0;
      cycle_cnt  = 0;
      last_due   = 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      cycle_cnt = cycle_cnt + 1;
      if (req_i && gnt_o) begin
        // next request waits 0 to 3 cycles
        gnt_wait_q <= 2'($urandom % 4);
        // response 1 to 3 cycles after the grant
        due = cycle_cnt + int'($urandom % 3);
        // keep responses in order, one per cycle
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(addr_i);
        pend_due.push_back(due);
      end else if (req_i && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      rvalid_o <= 1'b0;
      if (pend_due.size() != 0 && pend_due[0] <= cycle_cnt) begin
        rvalid_o <= 1'b1;
        // memory content is the inverted address
        rdata_o  <= ~pend_addr[0];
        // top nibble F is an unmapped region
        err_o    <= (pend_addr[0][31:28] == 4'hF);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

endmodule

// File: tb_if_stage.sv
`timescale 1ns/1ns

module tb_if_stage import if_pkg::*; ();

  localparam addr_t       HaltAddr  = 32'h1A110800;
  localparam addr_t       ExcAddr   = 32'h1A110808;
  localparam int unsigned Depth     = 3;
  localparam int unsigned MaxOut    = 2;
  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned NumTests  = 14;
  localparam int unsigned Seed      = 32'hbedeb4d0;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_id_t     irq_id_i;
  addr_t       boot_addr_i;
  addr_t       branch_target_i;
  addr_t       csr_mepc_i;
  addr_t       csr_depc_i;
  addr_t       csr_mtvec_i;
  logic        instr_valid_clear_i;
  logic        id_in_ready_i;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_err_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  instr_t      instr_rdata_id_o;
  logic        instr_fetch_err_o;
  addr_t       pc_id_o;
  addr_t       pc_if_o;
  logic        pc_mismatch_alert_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;

  // scoreboard state
  string       test_name;
  int          errors;
  int          checks;
  int          inflight;
  int          n_new;
  addr_t       exp_pc;
  addr_t       prev_addr;
  logic        prev_req;
  logic        prev_gnt;
  logic        prev_valid;
  logic        prev_clear;
  logic        prev_pc_set;
  logic        bp_en;

  if_stage #(
    .DmHaltAddr     (HaltAddr),
    .DmExceptionAddr(ExcAddr),
    .FifoDepth      (Depth),
    .MaxOutstanding (MaxOut)
  ) i_if_stage (
    .clk_i, .rst_ni, .req_i, .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .irq_id_i,
    .boot_addr_i, .branch_target_i, .csr_mepc_i, .csr_depc_i, .csr_mtvec_i,
    .instr_valid_clear_i, .id_in_ready_i, .instr_req_o, .instr_addr_o,
    .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i, .instr_err_i,
    .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o, .instr_fetch_err_o,
    .pc_id_o, .pc_if_o, .pc_mismatch_alert_o, .if_busy_o, .csr_mtvec_init_o
  );

  tb_instr_mem i_instr_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (instr_req_o),
    .addr_i  (instr_addr_o),
    .gnt_o   (instr_gnt_i),
    .rvalid_o(instr_rvalid_i),
    .rdata_o (instr_rdata_i),
    .err_o   (instr_err_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // reference model and check helpers
  ////////////////////////////////////////////////////////////

  // redirect target from the current selector and address inputs
  function automatic addr_t expected_target(input pc_sel_e sel, input exc_pc_sel_e exc);
    addr_t base;
    addr_t t;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    case (sel)
      PC_BOOT: t = (boot_addr_i & 32'hFFFF_FF00) | 32'h80;
      PC_JUMP: t = branch_target_i;
      PC_EXC: begin
        case (exc)
          EXC_PC_EXC: t = base;
          // vectored mode only when mtvec bit 0 is set
          EXC_PC_IRQ: t = csr_mtvec_i[0] ? base + {irq_id_i, 2'b00} : base;
          EXC_PC_DBD: t = HaltAddr;
          default:    t = ExcAddr;
        endcase
      end
      PC_ERET: t = csr_mepc_i;
      default: t = csr_depc_i;
    endcase
    return t & 32'hFFFF_FFFC;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  function automatic logic ready_value();
    if (bp_en) begin
      return ($urandom % 3) != 0;
    end
    return 1'b1;
  endfunction

  task automatic step_cycle();
    @(posedge clk_i);
    pc_set_i            <= 1'b0;
    instr_valid_clear_i <= ($urandom % 8) == 0;
    id_in_ready_i       <= ready_value();
  endtask

  // one redirect pulse, then wait for count new instructions
  task automatic redirect(input string name, input pc_sel_e sel, input exc_pc_sel_e exc,
                          input irq_id_t irq, input addr_t addr, input addr_t mtvec,
                          input int count);
    int start;
    @(posedge clk_i);
    test_name           = name;
    pc_set_i            <= 1'b1;
    pc_mux_i            <= sel;
    exc_pc_mux_i        <= exc;
    irq_id_i            <= irq;
    csr_mtvec_i         <= mtvec;
    instr_valid_clear_i <= 1'b1;
    id_in_ready_i       <= ready_value();
    case (sel)
      PC_BOOT: boot_addr_i     <= addr;
      PC_JUMP: branch_target_i <= addr;
      PC_ERET: csr_mepc_i      <= addr;
      PC_DRET: csr_depc_i      <= addr;
      default: ;
    endcase
    start = n_new;
    // count 0 leaves pc_set high for a back-to-back redirect
    while (count != 0 && n_new < start + count) begin
      step_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks at every rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      prev_req    = 1'b0;
      prev_gnt    = 1'b0;
      prev_valid  = 1'b0;
      prev_clear  = 1'b0;
      prev_pc_set = 1'b0;
      inflight    = 0;
    end else begin
      // an ungranted request keeps request and address
      if (prev_req && !prev_gnt) begin
        compare_value("req held", 1'b1, instr_req_o);
        compare_value("addr held", prev_addr, instr_addr_o);
      end
      if (instr_req_o) begin
        compare_value("addr aligned", 2'b00, instr_addr_o[1:0]);
      end
      if (instr_req_o && instr_gnt_i) begin
        inflight++;
      end
      if (instr_rvalid_i) begin
        inflight--;
      end
      checks++;
      assert (inflight >= 0 && inflight <= int'(MaxOut)) else begin
        errors++;
        $display("ERROR %s: %0d responses in flight on the bus", test_name, inflight);
      end
      // each new instruction is the next one of the stream
      if (instr_new_id_o) begin
        compare_value("pc", exp_pc, pc_id_o);
        compare_value("rdata", ~exp_pc, instr_rdata_id_o);
        compare_value("fetch err", exp_pc[31:28] == 4'hF, instr_fetch_err_o);
        exp_pc = exp_pc + 32'd4;
        n_new <= n_new + 1;
      end
      // fifo head is the next pc the stream expects
      compare_value("pc if", exp_pc, pc_if_o);
      if (prev_pc_set) begin
        compare_value("squash", 1'b0, instr_new_id_o);
      end
      compare_value("valid", instr_new_id_o | (prev_valid & ~prev_clear), instr_valid_id_o);
      compare_value("mtvec init", pc_set_i && pc_mux_i == PC_BOOT, csr_mtvec_init_o);
      compare_value("alert", 1'b0, pc_mismatch_alert_o);
      if (pc_set_i) begin
        exp_pc = expected_target(pc_mux_i, exc_pc_mux_i);
      end
      prev_req    = instr_req_o;
      prev_gnt    = instr_gnt_i;
      prev_addr   = instr_addr_o;
      prev_valid  = instr_valid_id_o;
      prev_clear  = instr_valid_clear_i;
      prev_pc_set = pc_set_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // directed sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(Seed));
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_id_i            = '0;
    boot_addr_i         = 32'h0000_2000;
    branch_target_i     = 32'h0000_4000;
    csr_mepc_i          = 32'h0000_3004;
    csr_depc_i          = 32'h0000_5008;
    csr_mtvec_i         = 32'h0000_8001;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = 1'b1;
    errors              = 0;
    checks              = 0;
    n_new               <= 0;
    exp_pc              = '0;
    bp_en               = 1'b0;
    test_name           = "reset";
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    req_i  <= 1'b1;
    // no fetch before the boot redirect
    repeat (3) begin
      @(posedge clk_i);
      compare_value("req", 1'b0, instr_req_o);
      compare_value("valid", 1'b0, instr_valid_id_o);
      compare_value("new", 1'b0, instr_new_id_o);
      compare_value("alert", 1'b0, pc_mismatch_alert_o);
      compare_value("busy", 1'b0, if_busy_o);
      compare_value("mtvec init", 1'b0, csr_mtvec_init_o);
    end
    redirect("boot", PC_BOOT, EXC_PC_EXC, 5'd0, 32'h0000_2000, 32'h0000_8001, 12);
    // target with a byte offset, the fetch drops it
    redirect("jump", PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_4002, 32'h0000_8001, 10);
    redirect("exc", PC_EXC, EXC_PC_EXC, 5'd3, '0, 32'h0000_8001, 8);
    redirect("irq vectored", PC_EXC, EXC_PC_IRQ, 5'd5, '0, 32'h0000_9001, 8);
    redirect("irq direct", PC_EXC, EXC_PC_IRQ, 5'd7, '0, 32'h0000_A000, 8);
    redirect("debug halt", PC_EXC, EXC_PC_DBD, 5'd0, '0, 32'h0000_A000, 8);
    redirect("debug exc", PC_EXC, EXC_PC_DBG_EXC, 5'd0, '0, 32'h0000_A000, 8);
    // id stage stalls at random from here on
    bp_en = 1'b1;
    redirect("eret", PC_ERET, EXC_PC_EXC, 5'd0, 32'h0000_3004, 32'h0000_A000, 10);
    redirect("dret", PC_DRET, EXC_PC_EXC, 5'd0, 32'h0000_5008, 32'h0000_A000, 10);
    redirect("bus error", PC_JUMP, EXC_PC_EXC, 5'd0, 32'hF000_0100, 32'h0000_A000, 10);
    redirect("quick 1", PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_6000, 32'h0000_A000, 0);
    redirect("quick 2", PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_7000, 32'h0000_A000, 0);
    redirect("quick 3", PC_ERET, EXC_PC_EXC, 5'd0, 32'h0000_3104, 32'h0000_A000, 12);
    redirect("irq back", PC_EXC, EXC_PC_IRQ, 5'd31, '0, 32'h0000_B001, 12);
    repeat (20) step_cycle();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NumTests * 400 * ClkPeriod);
    $display("ERROR: watchdog expired in test %s, instructions stopped arriving", test_name);
    $display("checks: %0d  errors: %0d", checks, errors + 1);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: sources.f
if_pkg.sv
if_pc_select.sv
if_fetch_fsm.sv
if_rsp_counter.sv
if_fetch_fifo.sv
if_id_reg.sv
if_stage.sv
tb_instr_mem.sv
tb_if_stage.sv
